// File: icache_top.f
+incdir+include
logic/icache_pkg.sv
logic/icache_miss_if.sv
logic/priority_select.sv
logic/icache_lookup.sv
logic/icache_mshr.sv
logic/icache_top.sv
testbench/icache_assert.sv
testbench/icache_tb.sv

// File: include/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// fetch ports, also the number of MSHR entries
`define ICACHE_PORTS 2

// direct-mapped geometry
`define ICACHE_LINES 32
`define ICACHE_INDEX_BITS 5
`define ICACHE_TAG_BITS 8
`define ICACHE_OFFSET_BITS 3

// full address word as seen by fetch and memory
`define ICACHE_ADDR_BITS 32
`define ICACHE_BLOCK_BITS 64

// memory transaction tag, zero means not accepted
`define MEM_TAG_BITS 4

`endif

// File: logic/icache_lookup.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_defs.svh"

module icache_lookup
    import icache_pkg::*;
(
    input  logic                                 clock,
    input  logic                                 reset,
    input  icache_addr_t [`ICACHE_PORTS-1:0]     fetch_addr,
    input  logic [`ICACHE_PORTS-1:0]             fetch_valid,
    input  mem_block_t                           mem_data,
    output mem_block_t [`ICACHE_PORTS-1:0]       data_out,
    output logic [`ICACHE_PORTS-1:0]            valid_out,
    icache_miss_if.lookup                        miss
);

    // direct-mapped array, one block per line
    icache_entry_t lines [`ICACHE_LINES];

    // entry read at each port's index
    icache_entry_t [`ICACHE_PORTS-1:0] port_entry;
    logic [`ICACHE_PORTS-1:0]          port_hit;

    for (genvar p = 0; p < `ICACHE_PORTS; p++) begin : g_port
        assign port_entry[p] = lines[fetch_addr[p].fields.index];

        assign port_hit[p] = fetch_valid[p]
                          && port_entry[p].valid
                          && port_entry[p].tag == fetch_addr[p].fields.tag;

        // hit path is purely combinational
        assign valid_out[p] = port_hit[p];
        assign data_out[p]  = port_hit[p] ? port_entry[p].block : '0;

        // misses go to the MSHR file every cycle until filled
        assign miss.miss_valid[p] = fetch_valid[p] && !port_hit[p];
        assign miss.miss_index[p] = fetch_addr[p].fields.index;
        assign miss.miss_tag[p]   = fetch_addr[p].fields.tag;
    end

    // fill write, the line hits from the next cycle on
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int l = 0; l < `ICACHE_LINES; l++) begin
                lines[l].valid <= 1'b0;
            end
        end else if (miss.fill_ready) begin
            lines[miss.fill_index].block <= mem_data;
            lines[miss.fill_index].tag   <= miss.fill_tag;
            lines[miss.fill_index].valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/icache_miss_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_defs.svh"

interface icache_miss_if;

    // one miss per fetch port, re-presented every cycle it persists
    logic [`ICACHE_PORTS-1:0]                         miss_valid;
    logic [`ICACHE_PORTS-1:0][`ICACHE_INDEX_BITS-1:0] miss_index;
    logic [`ICACHE_PORTS-1:0][`ICACHE_TAG_BITS-1:0]   miss_tag;

    // fill of one line, data comes straight from memory
    logic                          fill_ready;
    logic [`ICACHE_INDEX_BITS-1:0] fill_index;
    logic [`ICACHE_TAG_BITS-1:0]   fill_tag;

    modport lookup (
        output miss_valid,
        output miss_index,
        output miss_tag,
        input  fill_ready,
        input  fill_index,
        input  fill_tag
    );

    modport mshr (
        input  miss_valid,
        input  miss_index,
        input  miss_tag,
        output fill_ready,
        output fill_index,
        output fill_tag
    );

endinterface

`default_nettype wire

// File: logic/icache_mshr.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_defs.svh"

module icache_mshr
    import icache_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          squash,
    input  logic          dcache_request,
    input  mem_tag_t      mem_transaction_tag,
    input  mem_tag_t      mem_data_tag,
    output mem_command_t  mem_command,
    output icache_addr_t  mem_addr,
    icache_miss_if.mshr   miss
);

    mshr_entry_t [`ICACHE_PORTS-1:0] entries;
    mshr_entry_t [`ICACHE_PORTS-1:0] next_entries;

    logic [`ICACHE_PORTS-1:0] entry_free;
    logic [`ICACHE_PORTS-1:0] entry_wait_tag;
    logic [`ICACHE_PORTS-1:0] miss_dup;
    logic [`ICACHE_PORTS-1:0] miss_new;

    // grant r points at the r-th free entry
    logic [`ICACHE_PORTS-1:0][`ICACHE_PORTS-1:0] free_gnt_bus;
    logic [0:0][`ICACHE_PORTS-1:0]               issue_gnt_bus;
    logic                                        free_empty;
    logic                                        issue_empty;

    always_comb begin
        for (int e = 0; e < `ICACHE_PORTS; e++) begin
            entry_free[e]     = entries[e].state == MSHR_INVALID;
            entry_wait_tag[e] = entries[e].state == MSHR_WAIT_TAG;
        end
    end

    priority_select #(
        .WIDTH(`ICACHE_PORTS),
        .REQS (`ICACHE_PORTS)
    ) i_free_select (
        .req    (entry_free),
        .gnt_bus(free_gnt_bus),
        .empty  (free_empty)
    );

    // one load at a time, lowest waiting entry first
    priority_select #(
        .WIDTH(`ICACHE_PORTS),
        .REQS (1)
    ) i_issue_select (
        .req    (entry_wait_tag),
        .gnt_bus(issue_gnt_bus),
        .empty  (issue_empty)
    );

    // a miss is a duplicate if an entry or a lower port already has the line
    always_comb begin
        for (int p = 0; p < `ICACHE_PORTS; p++) begin
            miss_dup[p] = 1'b0;
            for (int e = 0; e < `ICACHE_PORTS; e++) begin
                if (entries[e].state != MSHR_INVALID
                 && entries[e].index == miss.miss_index[p]
                 && entries[e].tag == miss.miss_tag[p]) begin
                    miss_dup[p] = 1'b1;
                end
            end
            for (int q = 0; q < p; q++) begin
                if (miss.miss_valid[q]
                 && miss.miss_index[q] == miss.miss_index[p]
                 && miss.miss_tag[q] == miss.miss_tag[p]) begin
                    miss_dup[p] = 1'b1;
                end
            end
            miss_new[p] = miss.miss_valid[p] && !miss_dup[p];
        end
    end

    always_comb begin
        int rank;

        next_entries = entries;

        // returning data, tag zero means nothing arrives
        miss.fill_ready = 1'b0;
        miss.fill_index = '0;
        miss.fill_tag   = '0;
        for (int e = 0; e < `ICACHE_PORTS; e++) begin
            if (entries[e].state == MSHR_WAIT_DATA
             && mem_data_tag != '0
             && entries[e].transaction_tag == mem_data_tag) begin
                miss.fill_ready       = 1'b1;
                miss.fill_index       = entries[e].index;
                miss.fill_tag         = entries[e].tag;
                next_entries[e].state = MSHR_INVALID;
            end
        end

        // issue, held back while the data cache owns memory
        mem_command = MEM_NONE;
        mem_addr    = '0;
        if (!dcache_request && !issue_empty) begin
            for (int e = 0; e < `ICACHE_PORTS; e++) begin
                if (issue_gnt_bus[0][e]) begin
                    mem_command          = MEM_LOAD;
                    mem_addr.fields.tag   = entries[e].tag;
                    mem_addr.fields.index = entries[e].index;
                    // refused loads stay in WAIT_TAG and repeat
                    if (mem_transaction_tag != '0) begin
                        next_entries[e].transaction_tag = mem_transaction_tag;
                        next_entries[e].state           = MSHR_WAIT_DATA;
                    end
                end
            end
        end

        // k-th new miss takes the k-th free entry, the rest retry later
        rank = 0;
        for (int p = 0; p < `ICACHE_PORTS; p++) begin
            if (miss_new[p]) begin
                for (int e = 0; e < `ICACHE_PORTS; e++) begin
                    if (!free_empty && free_gnt_bus[rank][e]) begin
                        next_entries[e].state           = MSHR_WAIT_TAG;
                        next_entries[e].index           = miss.miss_index[p];
                        next_entries[e].tag             = miss.miss_tag[p];
                        next_entries[e].transaction_tag = '0;
                    end
                end
                rank = rank + 1;
            end
        end
    end

    // squash drops every outstanding miss, late data then matches nothing
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            for (int e = 0; e < `ICACHE_PORTS; e++) begin
                entries[e].state <= MSHR_INVALID;
            end
        end else begin
            entries <= next_entries;
        end
    end

endmodule

`default_nettype wire

// File: logic/icache_pkg.sv
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

    // 16 used address bits: tag, index, offset
    typedef struct packed {
        logic [`ICACHE_ADDR_BITS-`ICACHE_TAG_BITS-`ICACHE_INDEX_BITS
               -`ICACHE_OFFSET_BITS-1:0] upper;
        logic [`ICACHE_TAG_BITS-1:0]     tag;
        logic [`ICACHE_INDEX_BITS-1:0]   index;
        logic [`ICACHE_OFFSET_BITS-1:0]  offset;
    } icache_addr_fields_t;

    // one address word, seen either raw or split into fields
    typedef union packed {
        logic [`ICACHE_ADDR_BITS-1:0] raw;
        icache_addr_fields_t          fields;
    } icache_addr_t;

    typedef logic [`ICACHE_BLOCK_BITS-1:0] mem_block_t;
    typedef logic [`MEM_TAG_BITS-1:0]      mem_tag_t;

    typedef enum logic {
        MEM_NONE = 1'b0,
        MEM_LOAD = 1'b1
    } mem_command_t;

    typedef struct packed {
        mem_block_t                  block;
        logic [`ICACHE_TAG_BITS-1:0] tag;
        logic                        valid;
    } icache_entry_t;

    // invalid must stay zero
    typedef enum logic [1:0] {
        MSHR_INVALID   = 2'd0,
        MSHR_WAIT_TAG  = 2'd1,
        MSHR_WAIT_DATA = 2'd2
    } mshr_state_t;

    typedef struct packed {
        mshr_state_t                   state;
        logic [`ICACHE_INDEX_BITS-1:0] index;
        logic [`ICACHE_TAG_BITS-1:0]   tag;
        mem_tag_t                      transaction_tag;
    } mshr_entry_t;

endpackage

`default_nettype wire

// File: logic/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_defs.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              squash,
    input  logic                              dcache_request,

    // fetch side
    input  icache_addr_t [`ICACHE_PORTS-1:0]  fetch_addr,
    input  logic [`ICACHE_PORTS-1:0]          fetch_valid,
    output mem_block_t [`ICACHE_PORTS-1:0]    data_out,
    output logic [`ICACHE_PORTS-1:0]          valid_out,

    // memory side
    input  mem_tag_t                          mem_transaction_tag,
    input  mem_tag_t                          mem_data_tag,
    input  mem_block_t                        mem_data,
    output mem_command_t                      mem_command,
    output icache_addr_t                      mem_addr
);

    // misses forward, fills back
    icache_miss_if miss_bus ();

    icache_lookup i_lookup (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .fetch_valid(fetch_valid),
        .mem_data   (mem_data),
        .data_out   (data_out),
        .valid_out  (valid_out),
        .miss       (miss_bus.lookup)
    );

    icache_mshr i_mshr (
        .clock              (clock),
        .reset              (reset),
        .squash             (squash),
        .dcache_request     (dcache_request),
        .mem_transaction_tag(mem_transaction_tag),
        .mem_data_tag       (mem_data_tag),
        .mem_command        (mem_command),
        .mem_addr           (mem_addr),
        .miss               (miss_bus.mshr)
    );

endmodule

`default_nettype wire

// File: logic/priority_select.sv
`timescale 1ns/100ps
`default_nettype none

module priority_select #(
    parameter int WIDTH = 4,
    parameter int REQS  = 1
) (
    input  logic [WIDTH-1:0]           req,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus,
    output logic                       empty
);

    // requests not yet handed to a lower requester
    logic [REQS:0][WIDTH-1:0] remaining;

    assign remaining[0] = req;

    for (genvar r = 0; r < REQS; r++) begin : g_req
        // isolate lowest set bit
        assign gnt_bus[r] = remaining[r] & (~remaining[r] + WIDTH'(1));
        assign remaining[r+1] = remaining[r] & ~gnt_bus[r];
    end

    assign empty = ~|req;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f icache_top.f \
    --top-module icache_tb \
    -o sim_icache

./obj_dir/sim_icache +verilator+error+limit+100 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// File: testbench/icache_assert.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_defs.svh"

module icache_assert
    import icache_pkg::*;
(
    input logic                            clock,
    input logic                            reset,
    input logic                            dcache_request,
    input mem_command_t                    mem_command,
    input mshr_entry_t [`ICACHE_PORTS-1:0] entries
);

    // number of failed assertions
    int fail_count = 0;

    function automatic bit line_tracked_twice(mshr_entry_t [`ICACHE_PORTS-1:0] e);
        for (int a = 0; a < `ICACHE_PORTS; a++) begin
            for (int b = a + 1; b < `ICACHE_PORTS; b++) begin
                if (e[a].state != MSHR_INVALID && e[b].state != MSHR_INVALID
                 && e[a].index == e[b].index && e[a].tag == e[b].tag) begin
                    return 1'b1;
                end
            end
        end
        return 1'b0;
    endfunction

    // a second entry for one line means a merge was missed
    no_duplicate_lines: assert property (
        @(posedge clock) disable iff (reset) !line_tracked_twice(entries)
    ) else begin
        fail_count++;
        $error("two MSHR entries track the same line");
    end

    dcache_blocks_issue: assert property (
        @(posedge clock) disable iff (reset) dcache_request |-> mem_command == MEM_NONE
    ) else begin
        fail_count++;
        $error("load issued while the data cache owns memory");
    end

    // entries are all invalid in the first cycle out of reset
    idle_after_reset: assert property (
        @(posedge clock) $fell(reset) |-> mem_command == MEM_NONE
    ) else begin
        fail_count++;
        $error("load issued in the cycle after reset");
    end

endmodule

bind icache_mshr icache_assert i_assert (
    .clock         (clock),
    .reset         (reset),
    .dcache_request(dcache_request),
    .mem_command   (mem_command),
    .entries       (entries)
);

`default_nettype wire

// File: testbench/icache_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_defs.svh"

module icache_tb
    import icache_pkg::*;
();

    // one accepted load waiting in the memory model
    typedef struct {
        mem_tag_t     tag;
        icache_addr_t addr;
        int           due;
        bit           live;
    } pending_t;

    logic                             clock;
    logic                             reset;
    logic                             squash;
    logic                             dcache_request;
    icache_addr_t [`ICACHE_PORTS-1:0] fetch_addr;
    logic [`ICACHE_PORTS-1:0]         fetch_valid;
    mem_tag_t                         mem_transaction_tag = '0;
    mem_tag_t                         mem_data_tag = '0;
    mem_block_t                       mem_data = '0;
    mem_command_t                     mem_command;
    icache_addr_t                     mem_addr;
    mem_block_t [`ICACHE_PORTS-1:0]   data_out;
    logic [`ICACHE_PORTS-1:0]         valid_out;

    pending_t pending [$];
    pending_t in_flight;
    bit       in_flight_valid = 1'b0;
    mem_tag_t next_tag = mem_tag_t'(1);
    int       accept_pct = 100;
    int       cycle = 0;
    int       accepted_loads = 0;

    // shadow of the lines the cache should hold
    logic [`ICACHE_LINES-1:0]    shadow_valid = '0;
    logic [`ICACHE_TAG_BITS-1:0] shadow_tag [`ICACHE_LINES];

    int pool_index [6] = '{3, 3, 7, 12, 12, 20};
    int pool_tag   [6] = '{8'h61, 8'h72, 8'h61, 8'h83, 8'h94, 8'ha5};

    int error_count = 0;
    int check_count = 0;
    int test_count = 0;

    icache_top i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic icache_addr_t make_addr(int tag, int index, int offset);
        icache_addr_t a;
        a = '0;
        a.fields.tag    = tag[`ICACHE_TAG_BITS-1:0];
        a.fields.index  = index[`ICACHE_INDEX_BITS-1:0];
        a.fields.offset = offset[`ICACHE_OFFSET_BITS-1:0];
        return a;
    endfunction

    // memory contents follow from the line address alone
    function automatic mem_block_t block_of(icache_addr_t addr);
        return {2{addr.raw & ~32'h7}} ^ 64'h5a3c_96e1_0f87_c3d2;
    endfunction

    function automatic logic shadow_hit(icache_addr_t addr);
        return shadow_valid[addr.fields.index]
            && shadow_tag[addr.fields.index] == addr.fields.tag;
    endfunction

    function automatic bit tag_busy(mem_tag_t t);
        if (in_flight_valid && in_flight.tag == t) begin
            return 1'b1;
        end
        foreach (pending[i]) begin
            if (pending[i].tag == t) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_block(string name, mem_block_t got, mem_block_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAILED %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // address only matters for a load
    task automatic check_request(mem_command_t got_cmd, icache_addr_t got_addr,
                                 mem_command_t exp_cmd, icache_addr_t exp_addr);
        check_count++;
        if (got_cmd !== exp_cmd || (exp_cmd == MEM_LOAD && got_addr !== exp_addr)) begin
            error_count++;
            $display("FAILED mem_command/mem_addr: got %h/%h, expected %h/%h",
                     got_cmd, got_addr, exp_cmd, exp_addr);
        end
    endtask

    task automatic check_hit(string name, logic got, logic expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAILED %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic check_loads(int got, int expected);
        check_count++;
        if (got != expected) begin
            error_count++;
            $display("FAILED accepted loads: got %h, expected %h", got, expected);
        end
    endtask

    task automatic fetch_line(logic [`ICACHE_PORTS-1:0] ports, icache_addr_t addr);
        @(posedge clock);
        for (int p = 0; p < `ICACHE_PORTS; p++) begin
            fetch_valid[p] <= ports[p];
            fetch_addr[p]  <= addr;
        end
    endtask

    task automatic wait_hit(int port, int limit);
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!valid_out[port] && n < limit);
        if (!valid_out[port]) begin
            error_count++;
            $display("timeout: port %0d saw no hit within %0d cycles", port, limit);
        end
    endtask

    task automatic wait_load(int limit);
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (mem_command != MEM_LOAD && n < limit);
        if (mem_command != MEM_LOAD) begin
            error_count++;
            $display("timeout: no load was issued within %0d cycles", limit);
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // memory model, settles the cycle that just ended, then drives the next one
    always @(posedge clock) begin
        pending_t entry;
        int slot;
        if (reset) begin
            pending.delete();
            in_flight_valid = 1'b0;
            shadow_valid = '0;
            mem_transaction_tag <= '0;
            mem_data_tag <= '0;
            mem_data <= '0;
        end else begin
            cycle++;
            // a live return was written into the array at this edge
            if (in_flight_valid && in_flight.live) begin
                shadow_valid[in_flight.addr.fields.index] = 1'b1;
                shadow_tag[in_flight.addr.fields.index]   = in_flight.addr.fields.tag;
            end
            in_flight_valid = 1'b0;
            if (mem_command == MEM_LOAD && mem_transaction_tag != '0) begin
                foreach (pending[i]) begin
                    if (pending[i].live && pending[i].addr == mem_addr) begin
                        error_count++;
                        $display("second load accepted for line %h while one is outstanding",
                                 mem_addr);
                    end
                end
                entry.tag  = mem_transaction_tag;
                entry.addr = mem_addr;
                entry.due  = cycle + 1 + $urandom_range(8);
                entry.live = 1'b1;
                pending.push_back(entry);
                accepted_loads++;
            end
            // squashed misses still return, but must be dropped
            if (squash) begin
                foreach (pending[i]) begin
                    pending[i].live = 1'b0;
                end
            end
            slot = -1;
            foreach (pending[i]) begin
                if (slot < 0 && pending[i].due <= cycle) begin
                    slot = i;
                end
            end
            if (slot >= 0) begin
                in_flight       = pending[slot];
                in_flight_valid = 1'b1;
                pending.delete(slot);
                mem_data_tag <= in_flight.tag;
                mem_data     <= block_of(in_flight.addr);
            end else begin
                mem_data_tag <= '0;
                mem_data     <= '0;
            end
            for (int k = 0; k < (1 << `MEM_TAG_BITS) && tag_busy(next_tag); k++) begin
                next_tag = (next_tag == '1) ? mem_tag_t'(1) : next_tag + mem_tag_t'(1);
            end
            mem_transaction_tag <= ($urandom_range(99) < accept_pct) ? next_tag : '0;
        end
    end

    // hit data and data-cache priority, every cycle
    always @(negedge clock) begin
        if (!reset) begin
            for (int p = 0; p < `ICACHE_PORTS; p++) begin
                check_hit($sformatf("valid_out[%0d]", p), valid_out[p],
                          fetch_valid[p] && shadow_hit(fetch_addr[p]));
                if (valid_out[p]) begin
                    check_block($sformatf("data_out[%0d]", p), data_out[p],
                                block_of(fetch_addr[p]));
                end
            end
            if (dcache_request) begin
                check_request(mem_command, mem_addr, MEM_NONE, '0);
            end
        end
    end

    initial begin
        icache_addr_t line;
        int base;
        int loads;
        int k;
        int assert_fails;

        void'($urandom(32'h5743_d0ab));
        reset          = 1'b1;
        squash         = 1'b0;
        dcache_request = 1'b0;
        fetch_addr     = '0;
        fetch_valid    = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        base = error_count;
        @(negedge clock);
        check_request(mem_command, mem_addr, MEM_NONE, '0);
        finish_test("reset state", base);

        base = error_count;
        fetch_line(2'b01, make_addr(8'h11, 1, 4));
        wait_hit(0, 100);
        fetch_line(2'b00, '0);
        finish_test("eventual fill", base);

        base  = error_count;
        loads = accepted_loads;
        fetch_line(2'b11, make_addr(8'h22, 2, 0));
        wait_hit(0, 100);
        wait_hit(1, 100);
        check_loads(accepted_loads - loads, 1);
        fetch_line(2'b00, '0);
        finish_test("miss merging", base);

        base  = error_count;
        loads = accepted_loads;
        @(posedge clock);
        dcache_request <= 1'b1;
        fetch_line(2'b01, make_addr(8'h33, 4, 2));
        repeat (12) @(negedge clock);
        check_loads(accepted_loads - loads, 0);
        @(posedge clock);
        dcache_request <= 1'b0;
        wait_hit(0, 100);
        check_loads(accepted_loads - loads, 1);
        fetch_line(2'b00, '0);
        finish_test("dcache priority", base);

        base  = error_count;
        loads = accepted_loads;
        line  = make_addr(8'h44, 5, 0);
        @(posedge clock);
        accept_pct <= 0;
        fetch_line(2'b01, make_addr(8'h44, 5, 6));
        wait_load(20);
        repeat (8) begin
            check_request(mem_command, mem_addr, MEM_LOAD, line);
            @(negedge clock);
        end
        @(posedge clock);
        accept_pct <= 100;
        wait_hit(0, 100);
        check_loads(accepted_loads - loads, 1);
        fetch_line(2'b00, '0);
        finish_test("refused load", base);

        // squash right after the load is accepted, before data can return
        base = error_count;
        line = make_addr(8'h55, 6, 0);
        fetch_line(2'b01, line);
        wait_load(20);
        @(posedge clock);
        squash      <= 1'b1;
        fetch_valid <= '0;
        @(posedge clock);
        squash <= 1'b0;
        repeat (12) @(negedge clock);
        loads = accepted_loads;
        fetch_line(2'b01, line);
        @(negedge clock);
        check_hit("valid_out[0]", valid_out[0], 1'b0);
        wait_hit(0, 100);
        check_loads(accepted_loads - loads, 1);
        fetch_line(2'b00, '0);
        finish_test("squash", base);

        base = error_count;
        @(posedge clock);
        accept_pct <= 60;
        repeat (400) begin
            @(posedge clock);
            for (int p = 0; p < `ICACHE_PORTS; p++) begin
                k = $urandom_range(5);
                fetch_valid[p] <= ($urandom_range(3) != 0);
                fetch_addr[p]  <= make_addr(pool_tag[k], pool_index[k], $urandom_range(7));
            end
            dcache_request <= ($urandom_range(99) < 15);
            squash         <= ($urandom_range(99) < 3);
        end
        @(posedge clock);
        fetch_valid    <= '0;
        dcache_request <= 1'b0;
        squash         <= 1'b0;
        repeat (20) @(negedge clock);
        finish_test("random traffic", base);

        assert_fails = i_dut.i_mshr.i_assert.fail_count;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_count, check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
